// File: hw/rom_sys_cfg.svh
/*
  SDRAM memory map and bus widths of the ROM subsystem.
  Included by the package and by every module that needs a region offset.
  Offsets are SDRAM word addresses except ROM_PROM_START, a download byte address.
*/
`ifndef ROM_SYS_CFG_SVH
`define ROM_SYS_CFG_SVH

// Bus widths
`define ROM_SDRAM_AW 22
`define ROM_IOCTL_AW 25

// Region order: main at 0, then sound, scroll, objects, PROMs

// Sound CPU ROM, 16 kB
`define ROM_SND_START 22'h008000

// Scroll tiles, 16k entries of 32 bits
`define ROM_SCR_START 22'h00A000

// Objects, 32k entries of 32 bits
`define ROM_OBJ_START 22'h012000

// Colour PROMs, byte address in the download stream
`define ROM_PROM_START 25'h0044000

`endif

// File: hw/rom_sys_pkg.sv
/*
  Shared types of the ROM subsystem.
  Used by scoped name from the RTL and the SDRAM model.
*/
`default_nettype none

`include "rom_sys_cfg.svh"

package rom_sys_pkg;

    // SDRAM side
    typedef logic [`ROM_SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [15:0]              sdram_word_t;

    // Download stream byte address
    typedef logic [`ROM_IOCTL_AW-1:0] ioctl_addr_t;

    // ROM payloads
    typedef logic [7:0]  byte_t;
    // First SDRAM word of the burst sits in the low half
    typedef logic [31:0] gfx_word_t;

endpackage

`default_nettype wire

// File: hw/rom_dwnld.sv
/*
  ROM download converter.
  Turns ioctl byte writes into 16-bit SDRAM programming writes one cycle later,
  with byte swap and gfx address swizzle. PROM bytes go out on prom_we instead.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rom_sys_cfg.svh"

module rom_dwnld (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     downloading,
    input  wire rom_sys_pkg::ioctl_addr_t ioctl_addr,
    input  wire rom_sys_pkg::byte_t       ioctl_dout,
    input  wire logic                     ioctl_wr,
    output rom_sys_pkg::sdram_addr_t      prog_addr,
    output rom_sys_pkg::byte_t            prog_data,
    output logic [1:0]                    prog_mask,
    output logic                          prog_we,
    output logic                          prom_we
);

    // Region bounds in download byte addresses
    localparam rom_sys_pkg::ioctl_addr_t SCR_LO =
        rom_sys_pkg::ioctl_addr_t'(`ROM_SCR_START) << 1;
    localparam rom_sys_pkg::ioctl_addr_t OBJ_LO =
        rom_sys_pkg::ioctl_addr_t'(`ROM_OBJ_START) << 1;
    localparam rom_sys_pkg::ioctl_addr_t PROM_LO = `ROM_PROM_START;

    logic                     accept;
    logic                     in_scr;
    logic                     in_obj;
    logic                     in_prom;
    rom_sys_pkg::sdram_addr_t word_addr;
    rom_sys_pkg::sdram_addr_t gfx_addr;
    rom_sys_pkg::ioctl_addr_t prom_offset;

    assign accept  = ioctl_wr && downloading;
    assign in_scr  = ioctl_addr >= SCR_LO && ioctl_addr < OBJ_LO;
    assign in_obj  = ioctl_addr >= OBJ_LO && ioctl_addr < PROM_LO;
    assign in_prom = ioctl_addr >= PROM_LO;

    assign word_addr   = ioctl_addr[`ROM_SDRAM_AW:1];
    assign prom_offset = ioctl_addr - PROM_LO;

    // Board specific bit swizzle of the gfx regions
    always_comb begin
        gfx_addr = word_addr;
        if (in_scr) begin
            gfx_addr[0]   = ~word_addr[3];
            gfx_addr[3:1] =  word_addr[2:0];
        end
        if (in_obj) begin
            gfx_addr[0]   = ~word_addr[3];
            gfx_addr[1]   = ~word_addr[4];
            gfx_addr[5:2] = {word_addr[5], word_addr[2:0]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prog_we <= accept && !in_prom;
            prom_we <= accept && in_prom;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prog_addr <= in_prom ? prom_offset[`ROM_SDRAM_AW-1:0] : gfx_addr;
            prog_data <= ioctl_dout;
            // Active low, even bytes land in the upper half
            prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
        end
    end

endmodule

`default_nettype wire

// File: hw/rom_slot.sv
/*
  One cached ROM consumer slot.
  Requests a two-word SDRAM burst on a miss and keeps it as the cached entry.
  A 32-bit payload takes both words, an 8-bit one picks a byte from either word.
*/
`timescale 1ns/1ps
`default_nettype none

module rom_slot #(
    parameter type                      data_t = rom_sys_pkg::byte_t,
    parameter int                       AW     = 16,
    parameter rom_sys_pkg::sdram_addr_t OFFSET = '0
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     cs,
    input  wire logic [AW-1:0]            addr,
    input  wire logic                     req_ack,
    input  wire logic                     word_dst,
    input  wire logic                     word_rdy,
    input  wire rom_sys_pkg::sdram_word_t word_data,
    output data_t                         data,
    output logic                          ok,
    output logic                          req,
    output rom_sys_pkg::sdram_addr_t      req_addr
);

    localparam bit WIDE = $bits(data_t) > 8;

    rom_sys_pkg::sdram_addr_t cur_addr;
    rom_sys_pkg::sdram_addr_t tag;
    rom_sys_pkg::sdram_word_t word0;
    rom_sys_pkg::sdram_word_t word1;
    rom_sys_pkg::sdram_word_t sel_word;
    logic                     valid;
    logic                     busy;
    logic                     second;
    logic                     hit_lo;
    logic                     hit_hi;
    logic                     hit;

    assign cur_addr = OFFSET + (WIDE ? rom_sys_pkg::sdram_addr_t'(addr)
                                     : rom_sys_pkg::sdram_addr_t'(addr >> 1));

    // Byte slots also hit on the second word of the burst
    assign hit_lo = valid && cur_addr == tag;
    assign hit_hi = valid && !WIDE && cur_addr == tag + 1'b1;
    assign hit    = hit_lo || hit_hi;
    assign ok     = cs && hit;

    assign sel_word = hit_hi ? word1 : word0;

    always_comb begin
        if (WIDE) begin
            data = data_t'({word1, word0});
        end else begin
            // Swapped bytes, even address in the upper half
            data = data_t'(addr[0] ? sel_word[7:0] : sel_word[15:8]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req    <= 1'b0;
            busy   <= 1'b0;
            valid  <= 1'b0;
            second <= 1'b0;
        end else begin
            if (cs && !hit && !req && !busy) begin
                req   <= 1'b1;
                valid <= 1'b0;
            end
            if (req_ack) begin
                req  <= 1'b0;
                busy <= 1'b1;
            end
            if (word_dst) begin
                second <= 1'b1;
            end
            if (word_rdy) begin
                busy   <= 1'b0;
                valid  <= 1'b1;
                second <= 1'b0;
            end
        end
    end

    // Request address doubles as the tag once the burst is in
    always_ff @(posedge clk) begin
        if (cs && !hit && !req && !busy) begin
            req_addr <= cur_addr;
        end
        if (word_dst) begin
            if (second) begin
                word1 <= word_data;
            end else begin
                word0 <= word_data;
            end
        end
        if (word_rdy) begin
            tag <= req_addr;
        end
    end

endmodule

`default_nettype wire

// File: hw/rom_arbiter.sv
/*
  Fixed-priority sharing of the SDRAM read port among four ROM slots.
  Slot 0 has the highest priority. A grant holds from the request until
  data_rdy, and the SDRAM strobes are steered to the granted slot only.
*/
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     downloading,
    input  wire logic [3:0]               slot_req,
    input  wire rom_sys_pkg::sdram_addr_t slot0_addr,
    input  wire rom_sys_pkg::sdram_addr_t slot1_addr,
    input  wire rom_sys_pkg::sdram_addr_t slot2_addr,
    input  wire rom_sys_pkg::sdram_addr_t slot3_addr,
    input  wire logic                     sdram_ack,
    input  wire logic                     data_dst,
    input  wire logic                     data_rdy,
    input  wire rom_sys_pkg::sdram_word_t data_read,
    output logic                          sdram_req,
    output rom_sys_pkg::sdram_addr_t      sdram_addr,
    output logic [3:0]                    slot_ack,
    output logic [3:0]                    slot_dst,
    output logic [3:0]                    slot_rdy
);

    logic [3:0]               grant;
    logic [3:0]               pick;
    logic                     busy;
    logic                     launch;
    logic                     word_seen;
    rom_sys_pkg::sdram_addr_t pick_addr;

    // Lowest set bit wins
    always_comb begin
        pick = 4'b0000;
        for (int i = 3; i >= 0; i--) begin
            if (slot_req[i]) begin
                pick = 4'b0001 << i;
            end
        end
    end

    always_comb begin
        case (pick)
            4'b0001: pick_addr = slot0_addr;
            4'b0010: pick_addr = slot1_addr;
            4'b0100: pick_addr = slot2_addr;
            default: pick_addr = slot3_addr;
        endcase
    end

    assign launch = !busy && !downloading && |slot_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            grant     <= 4'b0000;
            sdram_req <= 1'b0;
            word_seen <= 1'b0;
        end else begin
            if (launch) begin
                busy      <= 1'b1;
                grant     <= pick;
                sdram_req <= 1'b1;
            end
            if (sdram_ack) begin
                sdram_req <= 1'b0;
            end
            // First word of the burst marks the read as under way
            if (busy && data_dst) begin
                word_seen <= 1'b1;
            end
            if (busy && data_rdy) begin
                busy      <= 1'b0;
                grant     <= 4'b0000;
                word_seen <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            sdram_addr <= pick_addr;
        end
    end

    assign slot_ack = grant & {4{sdram_ack}};
    assign slot_dst = grant & {4{data_dst}};
    assign slot_rdy = grant & {4{data_rdy && word_seen}};

endmodule

`default_nettype wire

// File: hw/rom_sys.sv
/*
  ROM subsystem top level.
  Download converter for SDRAM programming, plus four cached ROM slots
  (scroll, objects, sound CPU, main CPU) sharing the SDRAM read port.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rom_sys_cfg.svh"

module rom_sys (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    // ROM download
    input  wire logic                     downloading,
    input  wire rom_sys_pkg::ioctl_addr_t ioctl_addr,
    input  wire rom_sys_pkg::byte_t       ioctl_dout,
    input  wire logic                     ioctl_wr,
    output rom_sys_pkg::sdram_addr_t      prog_addr,
    output rom_sys_pkg::byte_t            prog_data,
    output logic [1:0]                    prog_mask,
    output logic                          prog_we,
    output logic                          prom_we,
    // SDRAM read port
    output logic                          sdram_req,
    output rom_sys_pkg::sdram_addr_t      sdram_addr,
    input  wire logic                     sdram_ack,
    input  wire logic                     data_dst,
    input  wire logic                     data_rdy,
    input  wire rom_sys_pkg::sdram_word_t data_read,
    // Consumers
    input  wire logic                     scr_cs,
    input  wire logic [13:0]              scr_addr,
    output rom_sys_pkg::gfx_word_t        scr_data,
    output logic                          scr_ok,
    input  wire logic                     obj_cs,
    input  wire logic [14:0]              obj_addr,
    output rom_sys_pkg::gfx_word_t        obj_data,
    output logic                          obj_ok,
    input  wire logic                     snd_cs,
    input  wire logic [13:0]              snd_addr,
    output rom_sys_pkg::byte_t            snd_data,
    output logic                          snd_ok,
    input  wire logic                     main_cs,
    input  wire logic [15:0]              main_addr,
    output rom_sys_pkg::byte_t            main_data,
    output logic                          main_ok
);

    // Slot order is also the priority order
    logic [3:0]               slot_req;
    logic [3:0]               slot_ack;
    logic [3:0]               slot_dst;
    logic [3:0]               slot_rdy;
    rom_sys_pkg::sdram_addr_t scr_req_addr;
    rom_sys_pkg::sdram_addr_t obj_req_addr;
    rom_sys_pkg::sdram_addr_t snd_req_addr;
    rom_sys_pkg::sdram_addr_t main_req_addr;

    rom_dwnld u_dwnld (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    rom_slot #(
        .data_t (rom_sys_pkg::gfx_word_t),
        .AW     (14),
        .OFFSET (`ROM_SCR_START)
    ) u_scr_slot (
        .clk       (clk),
        .arst_n    (arst_n),
        .cs        (scr_cs),
        .addr      (scr_addr),
        .req_ack   (slot_ack[0]),
        .word_dst  (slot_dst[0]),
        .word_rdy  (slot_rdy[0]),
        .word_data (data_read),
        .data      (scr_data),
        .ok        (scr_ok),
        .req       (slot_req[0]),
        .req_addr  (scr_req_addr)
    );

    rom_slot #(
        .data_t (rom_sys_pkg::gfx_word_t),
        .AW     (15),
        .OFFSET (`ROM_OBJ_START)
    ) u_obj_slot (
        .clk       (clk),
        .arst_n    (arst_n),
        .cs        (obj_cs),
        .addr      (obj_addr),
        .req_ack   (slot_ack[1]),
        .word_dst  (slot_dst[1]),
        .word_rdy  (slot_rdy[1]),
        .word_data (data_read),
        .data      (obj_data),
        .ok        (obj_ok),
        .req       (slot_req[1]),
        .req_addr  (obj_req_addr)
    );

    rom_slot #(
        .data_t (rom_sys_pkg::byte_t),
        .AW     (14),
        .OFFSET (`ROM_SND_START)
    ) u_snd_slot (
        .clk       (clk),
        .arst_n    (arst_n),
        .cs        (snd_cs),
        .addr      (snd_addr),
        .req_ack   (slot_ack[2]),
        .word_dst  (slot_dst[2]),
        .word_rdy  (slot_rdy[2]),
        .word_data (data_read),
        .data      (snd_data),
        .ok        (snd_ok),
        .req       (slot_req[2]),
        .req_addr  (snd_req_addr)
    );

    // Main CPU ROM starts at the bottom of the SDRAM
    rom_slot #(
        .data_t (rom_sys_pkg::byte_t),
        .AW     (16),
        .OFFSET ('0)
    ) u_main_slot (
        .clk       (clk),
        .arst_n    (arst_n),
        .cs        (main_cs),
        .addr      (main_addr),
        .req_ack   (slot_ack[3]),
        .word_dst  (slot_dst[3]),
        .word_rdy  (slot_rdy[3]),
        .word_data (data_read),
        .data      (main_data),
        .ok        (main_ok),
        .req       (slot_req[3]),
        .req_addr  (main_req_addr)
    );

    rom_arbiter u_arbiter (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .slot_req    (slot_req),
        .slot0_addr  (scr_req_addr),
        .slot1_addr  (obj_req_addr),
        .slot2_addr  (snd_req_addr),
        .slot3_addr  (main_req_addr),
        .sdram_ack   (sdram_ack),
        .data_dst    (data_dst),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .slot_ack    (slot_ack),
        .slot_dst    (slot_dst),
        .slot_rdy    (slot_rdy)
    );

endmodule

`default_nettype wire

// File: tests/sdram_model.sv
/*
  Behavioural SDRAM for the ROM subsystem testbench.
  Stores programming writes by byte mask and keeps PROM bytes apart.
  Answers each read request with an ack and a two-word burst after random delays.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rom_sys_cfg.svh"

module sdram_model (
    input  wire logic                     clk,
    input  wire rom_sys_pkg::sdram_addr_t prog_addr,
    input  wire rom_sys_pkg::byte_t       prog_data,
    input  wire logic [1:0]               prog_mask,
    input  wire logic                     prog_we,
    input  wire logic                     prom_we,
    input  wire logic                     sdram_req,
    input  wire rom_sys_pkg::sdram_addr_t sdram_addr,
    output logic                          sdram_ack,
    output logic                          data_dst,
    output logic                          data_rdy,
    output rom_sys_pkg::sdram_word_t      data_read
);

    // Word space below the PROMs
    localparam int WORDS = `ROM_PROM_START / 2;

    rom_sys_pkg::sdram_word_t mem [0:WORDS-1];
    rom_sys_pkg::byte_t       prom_mem [0:255];
    rom_sys_pkg::sdram_addr_t rd_addr;
    int                       delay;

    // Outputs change 1 ns after the rising edge
    task automatic drive_edge;
        @(posedge clk);
        #1;
    endtask

    // Mask bits are active low
    always @(posedge clk) begin
        if (prog_we) begin
            if (!prog_mask[1]) begin
                mem[prog_addr][15:8] <= prog_data;
            end
            if (!prog_mask[0]) begin
                mem[prog_addr][7:0] <= prog_data;
            end
        end
        if (prom_we) begin
            prom_mem[prog_addr[7:0]] <= prog_data;
        end
    end

    initial begin
        sdram_ack = 1'b0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            drive_edge();
            if (sdram_req) begin
                rd_addr = sdram_addr;
                delay   = $urandom_range(6, 1);
                repeat (delay) drive_edge();
                sdram_ack = 1'b1;
                drive_edge();
                sdram_ack = 1'b0;
                data_dst  = 1'b1;
                data_read = mem[rd_addr];
                drive_edge();
                data_dst = 1'b0;
                delay    = $urandom_range(3, 0);
                repeat (delay) drive_edge();
                // Second word closes the burst
                data_dst  = 1'b1;
                data_rdy  = 1'b1;
                data_read = mem[rd_addr + 1'b1];
                drive_edge();
                data_dst = 1'b0;
                data_rdy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_rom_sys.sv
/*
  Testbench of the ROM subsystem.
  Downloads a random ROM image, then fetches from the four slots against a
  behavioural SDRAM and compares with values rebuilt from the image.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rom_sys_cfg.svh"

module tb_rom_sys;

    localparam int TIMEOUT = 200;
    localparam int SND_W   = `ROM_SND_START;
    localparam int SCR_W   = `ROM_SCR_START;
    localparam int OBJ_W   = `ROM_OBJ_START;
    localparam int PROM_B  = `ROM_PROM_START;

    logic                     clk;
    logic                     arst_n;
    logic                     downloading;
    rom_sys_pkg::ioctl_addr_t ioctl_addr;
    rom_sys_pkg::byte_t       ioctl_dout;
    logic                     ioctl_wr;
    rom_sys_pkg::sdram_addr_t prog_addr;
    rom_sys_pkg::byte_t       prog_data;
    logic [1:0]               prog_mask;
    logic                     prog_we;
    logic                     prom_we;
    logic                     sdram_req;
    rom_sys_pkg::sdram_addr_t sdram_addr;
    logic                     sdram_ack;
    logic                     data_dst;
    logic                     data_rdy;
    rom_sys_pkg::sdram_word_t data_read;
    rom_sys_pkg::gfx_word_t   scr_data;
    rom_sys_pkg::gfx_word_t   obj_data;
    rom_sys_pkg::byte_t       snd_data;
    rom_sys_pkg::byte_t       main_data;
    logic                     scr_ok;
    logic                     obj_ok;
    logic                     snd_ok;
    logic                     main_ok;

    // Slot order: scroll, objects, sound, main
    logic [3:0]               cs_vec;
    logic [15:0]              addr_vec [0:3];
    logic [3:0]               ok_vec;
    rom_sys_pkg::byte_t       image [0:PROM_B+255];

    int                       errors;
    int                       timeouts;
    int                       ack_count;
    int                       last_addr;
    logic                     last_wr;
    logic                     last_dl;
    logic                     last_req;
    rom_sys_pkg::sdram_addr_t last_sdram_addr;
    logic                     in_flight;
    logic                     exp_prog;
    logic                     exp_prom;
    logic [1:0]               exp_mask;
    int                       c;
    int                       r;
    int                       i;
    int                       k;
    int                       s;

    assign ok_vec = {main_ok, snd_ok, obj_ok, scr_ok};

    rom_sys u_rom_sys (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_dst    (data_dst),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .scr_cs      (cs_vec[0]),
        .scr_addr    (addr_vec[0][13:0]),
        .scr_data    (scr_data),
        .scr_ok      (scr_ok),
        .obj_cs      (cs_vec[1]),
        .obj_addr    (addr_vec[1][14:0]),
        .obj_data    (obj_data),
        .obj_ok      (obj_ok),
        .snd_cs      (cs_vec[2]),
        .snd_addr    (addr_vec[2][13:0]),
        .snd_data    (snd_data),
        .snd_ok      (snd_ok),
        .main_cs     (cs_vec[3]),
        .main_addr   (addr_vec[3]),
        .main_data   (main_data),
        .main_ok     (main_ok)
    );

    sdram_model u_sdram (
        .clk        (clk),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prog_mask  (prog_mask),
        .prog_we    (prog_we),
        .prom_we    (prom_we),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_dst   (data_dst),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Download ranges: main, sound, scroll, objects, PROMs
    function automatic int range_base(input int n);
        case (n)
            0: return 0;
            1: return 2 * SND_W;
            2: return 2 * SCR_W;
            3: return 2 * OBJ_W;
            default: return PROM_B;
        endcase
    endfunction

    function automatic int range_len(input int n);
        return (n == 4) ? 256 : 'h1000;
    endfunction

    // Expected SDRAM word address of a download byte
    function automatic rom_sys_pkg::sdram_addr_t prog_word_addr(input int a);
        logic [21:0] w;
        logic [21:0] g;
        w = a >> 1;
        g = w;
        if (a >= 2 * SCR_W && a < 2 * OBJ_W) begin
            g[0]   = ~w[3];
            g[3:1] = w[2:0];
        end else if (a >= 2 * OBJ_W && a < PROM_B) begin
            g[0]   = ~w[3];
            g[1]   = ~w[4];
            g[4:2] = w[2:0];
            g[5]   = w[5];
        end
        return g;
    endfunction

    // SDRAM word rebuilt from the image by undoing swizzle and byte swap
    function automatic rom_sys_pkg::sdram_word_t sdram_word(input int ga);
        logic [21:0] g;
        logic [21:0] w;
        int          b;
        g = ga;
        w = g;
        if (ga >= SCR_W && ga < OBJ_W) begin
            w[2:0] = g[3:1];
            w[3]   = ~g[0];
        end else if (ga >= OBJ_W && ga < PROM_B / 2) begin
            w[2:0] = g[4:2];
            w[3]   = ~g[0];
            w[4]   = ~g[1];
            w[5]   = g[5];
        end
        b = 2 * int'(w);
        return {image[b], image[b + 1]};
    endfunction

    // Expected slot output, first burst word in the low half
    function automatic logic [31:0] slot_expect(input int n, input int a);
        case (n)
            0: return {sdram_word(SCR_W + a + 1), sdram_word(SCR_W + a)};
            1: return {sdram_word(OBJ_W + a + 1), sdram_word(OBJ_W + a)};
            2: return {24'h0, image[2 * SND_W + a]};
            default: return {24'h0, image[a]};
        endcase
    endfunction

    function automatic logic [31:0] slot_data(input int n);
        case (n)
            0: return scr_data;
            1: return obj_data;
            2: return {24'h0, snd_data};
            default: return {24'h0, main_data};
        endcase
    endfunction

    function automatic string slot_name(input int n);
        case (n)
            0: return "scroll";
            1: return "object";
            2: return "sound";
            default: return "main";
        endcase
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic drive_edge;
        @(posedge clk);
        #1;
    endtask

    task automatic check_idle(input string when);
        @(negedge clk);
        assert (!prog_we && !prom_we && !sdram_req && ok_vec == 4'b0000) else begin
            errors++;
            $display("[ERROR] %0t: outputs not idle %s", $time, when);
        end
    endtask

    task automatic reset_dut;
        arst_n = 1'b0;
        check_idle("during reset");
        drive_edge();
        drive_edge();
        arst_n = 1'b1;
        check_idle("after reset");
        drive_edge();
    endtask

    task automatic send_byte(input int a);
        ioctl_addr = a;
        ioctl_dout = image[a];
        ioctl_wr   = 1'b1;
        drive_edge();
        ioctl_wr = 1'b0;
        drive_edge();
    endtask

    // Waits until every slot in the mask shows ok
    task automatic wait_ok(input logic [3:0] mask);
        int n;
        bit done;
        done = 1'b0;
        for (n = 0; n < TIMEOUT && !done; n++) begin
            @(negedge clk);
            done = (ok_vec & mask) == mask;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout: ok never rose for slots %b", mask);
        end
        drive_edge();
    endtask

    task automatic single_fetch(input int n, input int a);
        int acks;
        cs_vec      = 4'b0000;
        addr_vec[n] = a;
        cs_vec[n]   = 1'b1;
        wait_ok(4'b0001 << n);
        cs_vec[n] = 1'b0;
        drive_edge();
        // Same address again must come from the cache
        acks      = ack_count;
        cs_vec[n] = 1'b1;
        @(negedge clk);
        assert (ok_vec[n]) else begin
            errors++;
            $display("[ERROR] %0t: %s slot missed cached address %h", $time, slot_name(n), a);
        end
        repeat (8) drive_edge();
        assert (ack_count == acks && !sdram_req) else begin
            errors++;
            $display("[ERROR] %0t: %s slot refetched cached address %h",
                     $time, slot_name(n), a);
        end
        cs_vec[n] = 1'b0;
        drive_edge();
    endtask

    task automatic change_addr(input int n);
        int a;
        a           = $urandom_range('h3FF, 0);
        cs_vec      = 4'b0000;
        addr_vec[n] = a;
        cs_vec[n]   = 1'b1;
        wait_ok(4'b0001 << n);
        addr_vec[n] = a + 'h200;
        @(negedge clk);
        assert (!ok_vec[n]) else begin
            errors++;
            $display("[ERROR] %0t: %s ok stayed high after address change", $time, slot_name(n));
        end
        wait_ok(4'b0001 << n);
        cs_vec[n] = 1'b0;
    endtask

    // Compares every DUT output against the reference each cycle
    always @(negedge clk) begin : compare
        exp_prog = arst_n && last_wr && last_dl && last_addr < PROM_B;
        exp_prom = arst_n && last_wr && last_dl && last_addr >= PROM_B;
        exp_mask = last_addr[0] ? 2'b10 : 2'b01;
        assert (prog_we == exp_prog && prom_we == exp_prom) else begin
            errors++;
            $display("[ERROR] %0t: prog_we %b prom_we %b, expected %b %b",
                     $time, prog_we, prom_we, exp_prog, exp_prom);
        end
        if (exp_prog) begin
            assert (prog_addr == prog_word_addr(last_addr) && prog_mask == exp_mask &&
                    prog_data == image[last_addr]) else begin
                errors++;
                $display("[ERROR] %0t: byte %h written as %h/%b/%h", $time, last_addr,
                         prog_addr, prog_mask, prog_data);
            end
        end
        if (exp_prom) begin
            assert (prog_addr == last_addr - PROM_B && prog_data == image[last_addr]) else begin
                errors++;
                $display("[ERROR] %0t: PROM byte %h written as %h/%h", $time, last_addr,
                         prog_addr, prog_data);
            end
        end
        assert (!(sdram_req && downloading)) else begin
            errors++;
            $display("[ERROR] %0t: sdram_req high during download", $time);
        end
        assert (!(sdram_req && in_flight)) else begin
            errors++;
            $display("[ERROR] %0t: new request while a read is outstanding", $time);
        end
        assert (!(sdram_req && last_req && sdram_addr != last_sdram_addr)) else begin
            errors++;
            $display("[ERROR] %0t: sdram_addr moved while sdram_req held", $time);
        end
        if (sdram_ack) begin
            in_flight = 1'b1;
            ack_count++;
        end
        if (data_rdy) begin
            in_flight = 1'b0;
        end
        for (c = 0; c < 4; c++) begin
            if (ok_vec[c]) begin
                assert (slot_data(c) == slot_expect(c, addr_vec[c])) else begin
                    errors++;
                    $display("[ERROR] %0t: %s data %h at %h, expected %h", $time, slot_name(c),
                             slot_data(c), addr_vec[c], slot_expect(c, addr_vec[c]));
                end
            end
        end
        last_wr         = ioctl_wr;
        last_dl         = downloading;
        last_addr       = ioctl_addr;
        last_req        = sdram_req;
        last_sdram_addr = sdram_addr;
    end

    initial begin
        void'($urandom(99));
        arst_n      = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        cs_vec      = 4'b0000;
        for (s = 0; s < 4; s++) begin
            addr_vec[s] = '0;
        end
        errors    = 0;
        timeouts  = 0;
        ack_count = 0;
        last_wr   = 1'b0;
        last_dl   = 1'b0;
        last_req  = 1'b0;
        last_addr = 0;
        in_flight = 1'b0;
        reset_dut();

        for (r = 0; r < 5; r++) begin
            for (i = 0; i < range_len(r); i++) begin
                image[range_base(r) + i] = $urandom;
            end
        end

        // Main slot waits through the whole download
        downloading = 1'b1;
        cs_vec[3]   = 1'b1;
        for (r = 0; r < 5; r++) begin
            for (i = 0; i < range_len(r); i++) begin
                send_byte(range_base(r) + i);
            end
        end
        downloading = 1'b0;
        send_byte(1);
        for (i = 0; i < 256; i++) begin
            assert (u_sdram.prom_mem[i] == image[PROM_B + i]) else begin
                errors++;
                $display("[ERROR] %0t: PROM byte %0d not stored", $time, i);
            end
        end
        wait_ok(4'b1000);

        for (s = 0; s < 4; s++) begin
            for (k = 0; k < 6; k++) begin
                single_fetch(s, $urandom_range(s < 2 ? 'h7FE : 'hFFF, 0));
            end
        end

        // All four slots compete for the read port
        for (k = 0; k < 8; k++) begin
            for (s = 0; s < 4; s++) begin
                addr_vec[s] = $urandom_range(s < 2 ? 'h7FE : 'hFFF, 0);
            end
            cs_vec = 4'b1111;
            wait_ok(4'b1111);
            cs_vec = 4'b0000;
            drive_edge();
        end

        for (s = 0; s < 4; s++) begin
            change_addr(s);
        end

        cs_vec = 4'b1111;
        reset_dut();

        $display("Run finished: %0d errors, %0d timeouts, %0d SDRAM reads",
                 errors, timeouts, ack_count);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/rom_sys_pkg.sv
hw/rom_dwnld.sv
hw/rom_slot.sv
hw/rom_arbiter.sv
hw/rom_sys.sv
tests/sdram_model.sv
tests/tb_rom_sys.sv
